// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= sources.f
TB_TOP    ?= mem_ctrl_tb
RTL_TOP   ?= mem_ctrl_top
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_STR  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TB_TOP) | tee /dev/stderr | grep -xF '$(PASS_STR)' > /dev/null

clean:
	rm -rf $(BUILD)

// ==== common/memctl_pkg.sv ====
// Widths, opcode fields, exception causes and bus structs shared by every memory-control block
`default_nettype none

package memctl_pkg;

	// Core and table sizes
	localparam int ILEN        = 32;
	localparam int ASID_W      = 4;
	localparam int VPN_W       = 12;
	localparam int TLB_ENTRIES = 8;
	localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
	localparam int DC_LINES    = 8;
	localparam int DC_IDX_W    = $clog2(DC_LINES);
	localparam int LINE_W      = 32;
	localparam int L2_ADDR_W   = 16;

	// L2 line address of d-cache line 0 for write-back
	localparam logic [L2_ADDR_W-1:0] DC_WB_BASE = 16'h0100;

	// Instruction fields used by the maintenance decoder
	localparam logic [6:0] OPCODE_MISC_MEM   = 7'b0001111;
	localparam logic [6:0] OPCODE_SYSTEM     = 7'b1110011;
	localparam logic [2:0] FUNCT3_FENCE_I    = 3'b001;
	localparam logic [2:0] FUNCT3_PRIV       = 3'b000;
	localparam logic [6:0] FUNCT7_SFENCE_VMA = 7'b0001001;

	// Cause values follow the RISC-V mcause numbering
	typedef enum logic [3:0] {
		E_I_ADDR_MISALIGNED = 4'd0,
		E_I_ACCESS_FAULT    = 4'd1,
		E_ILLEGAL_INSTR     = 4'd2,
		E_LD_ACCESS_FAULT   = 4'd5,
		E_ST_ACCESS_FAULT   = 4'd7,
		E_ENV_CALL          = 4'd8
	} except_code_t;

	typedef enum logic [1:0] {
		NoFlush   = 2'd0,
		FlushAll  = 2'd1,
		FlushASID = 2'd2
	} tlb_flush_e;

	typedef struct packed {
		logic              valid;
		logic [ILEN-1:0]   instr;
		logic [ASID_W-1:0] asid;
	} instr_commit_t;

	typedef struct packed {
		logic         valid;
		except_code_t code;
		logic         at_head;
	} except_t;

	typedef struct packed {
		logic                 valid;
		logic [TLB_IDX_W-1:0] index;
		logic [ASID_W-1:0]    asid;
		logic [VPN_W-1:0]     vpn;
	} tlb_fill_t;

	typedef struct packed {
		tlb_flush_e        kind;
		logic [ASID_W-1:0] asid;
	} tlb_cmd_t;

	typedef struct packed {
		logic                 write;
		logic [L2_ADDR_W-1:0] addr;
		logic [LINE_W-1:0]    data;
	} l2_req_t;

	// id names the requester the answer goes back to
	typedef struct packed {
		logic              id;
		logic [LINE_W-1:0] data;
	} l2_ans_t;

endpackage

`default_nettype wire

// ==== control/mem_control_fsm.sv ====
// Maintenance control FSM; turns committed fences and exceptions into flush, stall, abort and unit commands
`timescale 1ns/1ps
`default_nettype none

module mem_control_fsm (
	input  logic                      clk_i,
	input  logic                      rst_ni,
	input  memctl_pkg::instr_commit_t commit_i,
	input  memctl_pkg::except_t       except_i,
	input  logic                      sync_done_i,
	output logic                      flush_o,
	output logic                      stall_o,
	output logic                      abort_o,
	output logic                      sync_start_o,
	output memctl_pkg::tlb_cmd_t      tlb_cmd_o
);
	import memctl_pkg::*;

	typedef enum logic [1:0] {RESET, RUN, CMD, SYNC} state_t;

	state_t     state_q;
	state_t     state_d;
	logic       armed_q;
	logic       flush_q;
	logic       abort_q;
	logic       stall_q;
	logic       sync_start_q;
	tlb_cmd_t   tlb_cmd_q;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       dec_flush;
	logic       dec_abort;
	logic       dec_sync;
	tlb_cmd_t   dec_tlb;
	logic       dec_any;
	logic       reset_cycle;

	assign opcode = commit_i.instr[6:0];
	assign funct3 = commit_i.instr[14:12];
	assign funct7 = commit_i.instr[31:25];

	// Decode this cycle's strobes into the command shown next cycle
	always_comb begin
		dec_flush = 1'b0;
		dec_abort = 1'b0;
		dec_sync  = 1'b0;
		dec_tlb   = '{kind: NoFlush, asid: '0};
		if (commit_i.valid) begin
			if (opcode == OPCODE_MISC_MEM && funct3 == FUNCT3_FENCE_I) begin
				dec_flush = 1'b1;
			end
			if (opcode == OPCODE_SYSTEM && funct3 == FUNCT3_PRIV &&
			    funct7 == FUNCT7_SFENCE_VMA) begin
				// ASID 0 means every address space
				dec_tlb.kind = (commit_i.asid == '0) ? FlushAll : FlushASID;
				dec_tlb.asid = commit_i.asid;
			end
		end
		if (except_i.valid && except_i.at_head) begin
			case (except_i.code)
				E_I_ADDR_MISALIGNED, E_I_ACCESS_FAULT: begin
					dec_flush = 1'b1;
					dec_tlb   = '{kind: FlushAll, asid: '0};
				end
				E_LD_ACCESS_FAULT, E_ST_ACCESS_FAULT: dec_flush = 1'b1;
				E_ILLEGAL_INSTR: dec_abort = 1'b1;
				E_ENV_CALL: dec_sync = 1'b1;
				default: ;
			endcase
		end
	end

	assign dec_any = dec_flush | dec_abort | dec_sync | (dec_tlb.kind != NoFlush);

	always_comb begin
		state_d = state_q;
		case (state_q)
			// Held here until the first edge after reset release, then one full cycle
			RESET: state_d = armed_q ? RUN : RESET;
			RUN: state_d = dec_any ? CMD : RUN;
			CMD: begin
				if (sync_start_q) begin
					state_d = SYNC;
				end else begin
					state_d = dec_any ? CMD : RUN;
				end
			end
			SYNC: state_d = sync_done_i ? RUN : SYNC;
			default: state_d = RESET;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q      <= RESET;
			armed_q      <= 1'b0;
			flush_q      <= 1'b0;
			abort_q      <= 1'b0;
			stall_q      <= 1'b0;
			sync_start_q <= 1'b0;
			tlb_cmd_q    <= '{kind: NoFlush, asid: '0};
		end else begin
			state_q      <= state_d;
			armed_q      <= 1'b1;
			flush_q      <= 1'b0;
			abort_q      <= 1'b0;
			sync_start_q <= 1'b0;
			tlb_cmd_q    <= '{kind: NoFlush, asid: '0};
			case (state_q)
				RUN, CMD: begin
					// Strobes are dropped while a sync is pending
					if (!stall_q) begin
						flush_q      <= dec_flush;
						abort_q      <= dec_abort;
						tlb_cmd_q    <= dec_tlb;
						sync_start_q <= dec_sync;
						stall_q      <= dec_sync;
					end
				end
				SYNC: begin
					if (sync_done_i) begin
						stall_q <= 1'b0;
						flush_q <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	assign reset_cycle  = (state_q == RESET) && armed_q;
	assign flush_o      = flush_q | reset_cycle;
	assign abort_o      = abort_q;
	assign stall_o      = stall_q;
	assign sync_start_o = sync_start_q;
	assign tlb_cmd_o    = reset_cycle ? '{kind: FlushAll, asid: '0} : tlb_cmd_q;

	// The write-back is started once on the way in, never again while it runs
	a_no_start_in_sync: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_q == SYNC) |-> !sync_start_o);

endmodule

`default_nettype wire

// ==== logic/dcache_sync_unit.sv ====
// D-cache synchronizer; tracks dirty lines and writes each one back to L2 when a sync is started
`timescale 1ns/1ps
`default_nettype none

module dcache_sync_unit (
	input  logic                            clk_i,
	input  logic                            rst_ni,
	input  logic                            dirty_valid_i,
	input  logic [memctl_pkg::DC_IDX_W-1:0] dirty_index_i,
	input  logic [memctl_pkg::LINE_W-1:0]   dirty_data_i,
	input  logic                            sync_start_i,
	output logic                            sync_done_o,
	output logic                            req_valid_o,
	output memctl_pkg::l2_req_t             req_o,
	input  logic                            req_ready_i,
	input  logic                            ans_valid_i,
	output logic                            ans_ready_o
);
	import memctl_pkg::*;

	typedef enum logic [2:0] {IDLE, SCAN, REQ, WAIT, DONE} state_t;

	state_t              state_q;
	logic [DC_LINES-1:0] dirty_q;
	logic [LINE_W-1:0]   data_q [DC_LINES];
	logic [DC_IDX_W-1:0] idx_q;
	logic                redirty_q;
	l2_req_t             req_q;
	logic                found;
	logic [DC_IDX_W-1:0] first_idx;

	// Lowest dirty index wins
	always_comb begin
		found     = 1'b0;
		first_idx = '0;
		for (int i = DC_LINES - 1; i >= 0; i--) begin
			if (dirty_q[i]) begin
				found     = 1'b1;
				first_idx = DC_IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q   <= IDLE;
			dirty_q   <= '0;
			idx_q     <= '0;
			redirty_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (sync_start_i) begin
						state_q <= SCAN;
					end
				end
				SCAN: begin
					if (found) begin
						idx_q     <= first_idx;
						redirty_q <= dirty_valid_i && (dirty_index_i == first_idx);
						state_q   <= REQ;
					end else begin
						state_q <= DONE;
					end
				end
				REQ: begin
					if (req_ready_i) begin
						state_q <= WAIT;
					end
				end
				WAIT: begin
					// A line written again during its write-back stays dirty
					if (ans_valid_i) begin
						dirty_q[idx_q] <= redirty_q;
						state_q        <= SCAN;
					end
				end
				DONE: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
			if ((state_q == REQ || state_q == WAIT) && dirty_valid_i &&
			    dirty_index_i == idx_q) begin
				redirty_q <= 1'b1;
			end
			if (dirty_valid_i) begin
				dirty_q[dirty_index_i] <= 1'b1;
			end
		end
	end

	// Line data and the request snapshot taken when a line is picked
	always_ff @(posedge clk_i) begin
		if (dirty_valid_i) begin
			data_q[dirty_index_i] <= dirty_data_i;
		end
		if (state_q == SCAN && found) begin
			req_q.write <= 1'b1;
			req_q.addr  <= DC_WB_BASE + L2_ADDR_W'(first_idx);
			req_q.data  <= data_q[first_idx];
		end
	end

	assign req_valid_o = (state_q == REQ);
	assign req_o       = req_q;
	assign ans_ready_o = (state_q == WAIT);
	assign sync_done_o = (state_q == DONE);

	a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(req_valid_o && !req_ready_i) |=> (req_valid_o && $stable(req_o)));

endmodule

`default_nettype wire

// ==== logic/l2_arbiter.sv ====
// Two-requester round-robin arbiter onto a single L2 port; answers return by requester id
`timescale 1ns/1ps
`default_nettype none

module l2_arbiter #(
	parameter type payload_t = logic
) (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                req_valid_i [2],
	input  payload_t            req_i [2],
	output logic                req_ready_o [2],
	output logic                l2_req_valid_o,
	output payload_t            l2_req_o,
	output logic                l2_req_id_o,
	input  logic                l2_req_ready_i,
	input  logic                l2_ans_valid_i,
	input  memctl_pkg::l2_ans_t l2_ans_i,
	output logic                l2_ans_ready_o,
	output logic                ans_valid_o [2],
	input  logic                ans_ready_i [2]
);

	logic prio_q;
	logic lock_q;
	logic gnt_q;
	logic gnt;

	// A stalled grant is kept so the L2 side sees the same request
	always_comb begin
		if (lock_q) begin
			gnt = gnt_q;
		end else if (req_valid_i[0] && req_valid_i[1]) begin
			gnt = prio_q;
		end else begin
			gnt = req_valid_i[1];
		end
	end

	assign l2_req_valid_o = req_valid_i[gnt];
	assign l2_req_o       = req_i[gnt];
	assign l2_req_id_o    = gnt;
	assign req_ready_o[0] = l2_req_ready_i && (gnt == 1'b0);
	assign req_ready_o[1] = l2_req_ready_i && (gnt == 1'b1);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			prio_q <= 1'b0;
			lock_q <= 1'b0;
			gnt_q  <= 1'b0;
		end else begin
			lock_q <= l2_req_valid_o && !l2_req_ready_i;
			gnt_q  <= gnt;
			// Other side gets priority after each accepted request
			if (l2_req_valid_o && l2_req_ready_i) begin
				prio_q <= ~gnt;
			end
		end
	end

	// Answer demux
	assign ans_valid_o[0] = l2_ans_valid_i && (l2_ans_i.id == 1'b0);
	assign ans_valid_o[1] = l2_ans_valid_i && (l2_ans_i.id == 1'b1);
	assign l2_ans_ready_o = ans_ready_i[l2_ans_i.id];

endmodule

`default_nettype wire

// ==== logic/mem_ctrl_top.sv ====
// Memory-maintenance controller top; joins the control FSM, TLB unit, d-cache sync and L2 arbiter
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top (
	input  logic                            clk_i,
	input  logic                            rst_ni,
	input  memctl_pkg::instr_commit_t       commit_i,
	input  memctl_pkg::except_t             except_i,
	output logic                            flush_o,
	output logic                            stall_o,
	output logic                            abort_o,
	input  memctl_pkg::tlb_fill_t           tlb_fill_i,
	input  logic [memctl_pkg::ASID_W-1:0]   lookup_asid_i,
	input  logic [memctl_pkg::VPN_W-1:0]    lookup_vpn_i,
	output logic                            tlb_hit_o,
	input  logic                            dirty_valid_i,
	input  logic [memctl_pkg::DC_IDX_W-1:0] dirty_index_i,
	input  logic [memctl_pkg::LINE_W-1:0]   dirty_data_i,
	input  logic                            refill_valid_i,
	input  memctl_pkg::l2_req_t             refill_req_i,
	output logic                            refill_ready_o,
	output logic                            refill_ans_valid_o,
	output logic [memctl_pkg::LINE_W-1:0]   refill_ans_data_o,
	input  logic                            refill_ans_ready_i,
	output logic                            l2_req_valid_o,
	output memctl_pkg::l2_req_t             l2_req_o,
	output logic                            l2_req_id_o,
	input  logic                            l2_req_ready_i,
	input  logic                            l2_ans_valid_i,
	input  memctl_pkg::l2_ans_t             l2_ans_i,
	output logic                            l2_ans_ready_o
);
	import memctl_pkg::*;

	tlb_cmd_t tlb_cmd;
	logic     sync_start;
	logic     sync_done;
	logic     sync_ans_ready;
	logic     arb_req_valid [2];
	l2_req_t  arb_req [2];
	logic     arb_req_ready [2];
	logic     arb_ans_valid [2];
	logic     arb_ans_ready [2];

	// Requester 1 is the instruction refill port
	assign arb_req_valid[1]   = refill_valid_i;
	assign arb_req[1]         = refill_req_i;
	assign refill_ready_o     = arb_req_ready[1];
	assign refill_ans_valid_o = arb_ans_valid[1];
	assign arb_ans_ready[1]   = refill_ans_ready_i;
	assign refill_ans_data_o  = l2_ans_i.data;
	assign arb_ans_ready[0]   = sync_ans_ready;

	mem_control_fsm u_fsm (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.commit_i     (commit_i),
		.except_i     (except_i),
		.sync_done_i  (sync_done),
		.flush_o      (flush_o),
		.stall_o      (stall_o),
		.abort_o      (abort_o),
		.sync_start_o (sync_start),
		.tlb_cmd_o    (tlb_cmd)
	);

	tlb_maint_unit u_tlb (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.fill_i        (tlb_fill_i),
		.cmd_i         (tlb_cmd),
		.lookup_asid_i (lookup_asid_i),
		.lookup_vpn_i  (lookup_vpn_i),
		.hit_o         (tlb_hit_o)
	);

	dcache_sync_unit u_dsync (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.dirty_valid_i (dirty_valid_i),
		.dirty_index_i (dirty_index_i),
		.dirty_data_i  (dirty_data_i),
		.sync_start_i  (sync_start),
		.sync_done_o   (sync_done),
		.req_valid_o   (arb_req_valid[0]),
		.req_o         (arb_req[0]),
		.req_ready_i   (arb_req_ready[0]),
		.ans_valid_i   (arb_ans_valid[0]),
		.ans_ready_o   (sync_ans_ready)
	);

	l2_arbiter #(
		.payload_t (l2_req_t)
	) u_arb (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.req_valid_i    (arb_req_valid),
		.req_i          (arb_req),
		.req_ready_o    (arb_req_ready),
		.l2_req_valid_o (l2_req_valid_o),
		.l2_req_o       (l2_req_o),
		.l2_req_id_o    (l2_req_id_o),
		.l2_req_ready_i (l2_req_ready_i),
		.l2_ans_valid_i (l2_ans_valid_i),
		.l2_ans_i       (l2_ans_i),
		.l2_ans_ready_o (l2_ans_ready_o),
		.ans_valid_o    (arb_ans_valid),
		.ans_ready_i    (arb_ans_ready)
	);

endmodule

`default_nettype wire

// ==== logic/tlb_maint_unit.sv ====
// Data TLB tag table; filled per entry, looked up combinationally, flushed whole or by ASID
`timescale 1ns/1ps
`default_nettype none

module tlb_maint_unit (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  memctl_pkg::tlb_fill_t         fill_i,
	input  memctl_pkg::tlb_cmd_t          cmd_i,
	input  logic [memctl_pkg::ASID_W-1:0] lookup_asid_i,
	input  logic [memctl_pkg::VPN_W-1:0]  lookup_vpn_i,
	output logic                          hit_o
);
	import memctl_pkg::*;

	logic [TLB_ENTRIES-1:0] valid_q;
	logic [ASID_W-1:0]      asid_q [TLB_ENTRIES];
	logic [VPN_W-1:0]       vpn_q [TLB_ENTRIES];
	logic [TLB_ENTRIES-1:0] match;

	// A flush takes the cycle, any fill alongside it is dropped
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
		end else begin
			case (cmd_i.kind)
				FlushAll: valid_q <= '0;
				FlushASID: begin
					for (int i = 0; i < TLB_ENTRIES; i++) begin
						if (asid_q[i] == cmd_i.asid) begin
							valid_q[i] <= 1'b0;
						end
					end
				end
				default: begin
					if (fill_i.valid) begin
						valid_q[fill_i.index] <= 1'b1;
					end
				end
			endcase
		end
	end

	// Tag payload
	always_ff @(posedge clk_i) begin
		if (fill_i.valid && cmd_i.kind == NoFlush) begin
			asid_q[fill_i.index] <= fill_i.asid;
			vpn_q[fill_i.index]  <= fill_i.vpn;
		end
	end

	always_comb begin
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			match[i] = valid_q[i] && (asid_q[i] == lookup_asid_i) &&
			           (vpn_q[i] == lookup_vpn_i);
		end
	end

	assign hit_o = |match;

	// Fill index comes from outside the unit and must name a real entry
	a_fill_index_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
		fill_i.valid |-> (int'(fill_i.index) < TLB_ENTRIES));

endmodule

`default_nettype wire

// ==== sources.f ====
common/memctl_pkg.sv
control/mem_control_fsm.sv
logic/tlb_maint_unit.sv
logic/dcache_sync_unit.sv
logic/l2_arbiter.sv
logic/mem_ctrl_top.sv
verification/tb_clock_gen.sv
verification/mem_ctrl_tb.sv

// ==== verification/mem_ctrl_stimulus.txt ====
# op a b c d, all hex. 0 reset-fill idx asid vpn | 1 fill idx asid vpn | 2 lookup asid vpn hit
# 3 commit instr asid exp | 4 except code at_head exp | 5 dirty idx data | 6 sync writes refills
0 0 3 0ab 0
2 3 0ab 0 0
1 0 3 010 0
1 1 3 011 0
1 2 5 012 0
1 3 5 013 0
2 3 010 1 0
2 5 013 1 0
3 12000073 3 2 0
2 3 010 0 0
2 3 011 0 0
2 5 012 1 0
3 12000073 0 1 0
2 5 012 0 0
2 5 013 0 0
3 0000100f 0 8 0
4 2 1 4 0
1 4 7 020 0
2 7 020 1 0
4 1 1 9 0
2 7 020 0 0
1 4 7 020 0
4 5 1 8 0
4 7 1 8 0
2 7 020 1 0
4 2 0 0 0
4 1 0 0 0
2 7 020 1 0
5 1 11111111 0 0
5 4 44444444 0 0
5 6 66666666 0 0
6 3 0 0 0
6 0 0 0 0
5 0 a0a0a0a0 0 0
5 2 c2c2c2c2 0 0
5 5 f5f5f5f5 0 0
5 7 17171717 0 0
6 4 5 0 0

// ==== verification/mem_ctrl_tb.sv ====
// Testbench for the memory-maintenance controller; runs the stimulus file and models L2
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_tb;
	import memctl_pkg::*;

	logic                clk_i;
	logic                rst_ni;
	instr_commit_t       commit_i;
	except_t             except_i;
	logic                flush_o;
	logic                stall_o;
	logic                abort_o;
	tlb_fill_t           tlb_fill_i;
	logic [ASID_W-1:0]   lookup_asid_i;
	logic [VPN_W-1:0]    lookup_vpn_i;
	logic                tlb_hit_o;
	logic                dirty_valid_i;
	logic [DC_IDX_W-1:0] dirty_index_i;
	logic [LINE_W-1:0]   dirty_data_i;
	logic                refill_valid_i;
	l2_req_t             refill_req_i;
	logic                refill_ready_o;
	logic                refill_ans_valid_o;
	logic [LINE_W-1:0]   refill_ans_data_o;
	logic                refill_ans_ready_i;
	logic                l2_req_valid_o;
	l2_req_t             l2_req_o;
	logic                l2_req_id_o;
	logic                l2_req_ready_i;
	logic                l2_ans_valid_i;
	l2_ans_t             l2_ans_i;
	logic                l2_ans_ready_o;

	int val_errs = 0;
	int other_errs = 0;
	int cyc = 0;

	// L2 model state
	logic                 busy = 1'b0;
	int                   ready_due;
	logic                 start_both;
	logic                 start_id;
	l2_req_t              start_req;
	logic                 have_last = 1'b0;
	logic                 last_id;
	logic                 ans_id_q [$];
	logic [LINE_W-1:0]    ans_data_q [$];
	int                   ans_due_q [$];
	logic [L2_ADDR_W-1:0] wr_addr_q [$];
	logic [LINE_W-1:0]    wr_data_q [$];

	// Refill requester and expected d-cache contents
	int                refill_todo = 0;
	logic              rf_acc = 1'b0;
	logic [15:0]       rf_seq = '0;
	logic [LINE_W-1:0] rf_exp_q [$];
	logic              exp_dirty [DC_LINES];
	logic [LINE_W-1:0] exp_data [DC_LINES];

	tb_clock_gen clk_gen (
		.clk_o  (clk_i),
		.rst_no (rst_ni)
	);

	mem_ctrl_top mem_ctrl_top_inst (.*);

	task automatic compare_value(input string name, input logic [31:0] exp,
	                             input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		other_errs++;
	endtask

	// Called one cycle after a strobe; exp is {flush, abort, tlb kind}
	task automatic check_pulse(input logic [31:0] exp);
		compare_value("flush_o", 32'(exp[3]), 32'(flush_o));
		compare_value("abort_o", 32'(exp[2]), 32'(abort_o));
		compare_value("tlb_cmd.kind", 32'(exp[1:0]), 32'(mem_ctrl_top_inst.tlb_cmd.kind));
		@(negedge clk_i);
		compare_value("flush_o after pulse", 32'd0, 32'(flush_o));
		compare_value("abort_o after pulse", 32'd0, 32'(abort_o));
		compare_value("tlb_cmd.kind after pulse", 32'd0,
		              32'(mem_ctrl_top_inst.tlb_cmd.kind));
	endtask

	// L2 model drives answers and ready at the falling edge and judges handshakes just after
	always begin
		@(negedge clk_i);
		cyc++;
		l2_ans_valid_i = 1'b0;
		if (ans_due_q.size() > 0 && cyc >= ans_due_q[0]) begin
			l2_ans_valid_i = 1'b1;
			l2_ans_i.id    = ans_id_q[0];
			l2_ans_i.data  = ans_data_q[0];
		end
		#1;
		if (l2_req_valid_o && !busy) begin
			busy       = 1'b1;
			ready_due  = cyc + int'($urandom_range(3, 0));
			start_both = mem_ctrl_top_inst.arb_req_valid[0] && refill_valid_i;
			start_req  = l2_req_o;
			start_id   = l2_req_id_o;
		end else if (busy && (l2_req_o !== start_req || l2_req_id_o !== start_id)) begin
			$display("At %0t a stalled L2 request changed before it was accepted", $time);
			other_errs++;
		end
		l2_req_ready_i = busy && (cyc >= ready_due);
		#1;
		if (l2_ans_valid_i && l2_ans_ready_o) begin
			void'(ans_id_q.pop_front());
			void'(ans_data_q.pop_front());
			void'(ans_due_q.pop_front());
		end
		if (l2_req_valid_o && l2_req_ready_i) begin
			if (start_both && have_last && l2_req_id_o == last_id) begin
				$display("At %0t the grant did not alternate between two requesters", $time);
				other_errs++;
			end
			have_last = 1'b1;
			last_id   = l2_req_id_o;
			if (l2_req_o.write) begin
				wr_addr_q.push_back(l2_req_o.addr);
				wr_data_q.push_back(l2_req_o.data);
			end
			ans_id_q.push_back(l2_req_id_o);
			ans_data_q.push_back(l2_req_o.data);
			ans_due_q.push_back(cyc + int'($urandom_range(3, 1)));
			busy = 1'b0;
		end
	end

	// Refill port keeps a read pending while it has requests left
	always begin
		@(negedge clk_i);
		if (rf_acc) begin
			refill_valid_i = 1'b0;
			rf_acc         = 1'b0;
		end
		if (!refill_valid_i && refill_todo > 0) begin
			refill_valid_i     = 1'b1;
			refill_req_i.write = 1'b0;
			refill_req_i.addr  = 16'h8000 + rf_seq;
			refill_req_i.data  = $urandom;
			rf_seq++;
		end
		#3;
		if (refill_valid_i && refill_ready_o) begin
			rf_acc = 1'b1;
			refill_todo--;
			rf_exp_q.push_back(refill_req_i.data);
		end
		if (refill_ans_valid_o) begin
			if (rf_exp_q.size() == 0) begin
				$display("At %0t a refill answer came with no refill outstanding", $time);
				other_errs++;
			end else begin
				compare_value("refill_ans_data_o", rf_exp_q[0], refill_ans_data_o);
				void'(rf_exp_q.pop_front());
			end
		end
	end

	initial begin
		int                fd;
		int                code;
		int                n;
		int                t;
		int                k;
		string             line;
		logic [31:0]       op;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       c;
		logic [31:0]       d;
		commit_i           = '0;
		except_i           = '0;
		tlb_fill_i         = '0;
		lookup_asid_i      = '0;
		lookup_vpn_i       = '0;
		dirty_valid_i      = 1'b0;
		dirty_index_i      = '0;
		dirty_data_i       = '0;
		refill_valid_i     = 1'b0;
		refill_req_i       = '0;
		refill_ans_ready_i = 1'b1;
		l2_req_ready_i     = 1'b0;
		l2_ans_valid_i     = 1'b0;
		l2_ans_i           = '0;
		for (int i = 0; i < DC_LINES; i++) begin
			exp_dirty[i] = 1'b0;
			exp_data[i]  = '0;
		end
		void'($urandom(32'h92ea3bd8));
		fd = $fopen("verification/mem_ctrl_stimulus.txt", "r");
		if (fd == 0) begin
			$display("The stimulus file could not be opened");
			other_errs++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code <= 0 || line.len() < 2 || line[0] == "#") begin
					continue;
				end
				d = '0;
				n = $sscanf(line, "%h %h %h %h %h", op, a, b, c, d);
				if (n < 4) begin
					continue;
				end
				case (op)
					// Fill held into the first edge after release, then the reset flush pulse
					0: begin
						tlb_fill_i = '{valid: 1'b1, index: a[TLB_IDX_W-1:0],
						               asid: b[ASID_W-1:0], vpn: c[VPN_W-1:0]};
						t = 0;
						while (!rst_ni && t < 100) begin
							@(negedge clk_i);
							t++;
						end
						if (!rst_ni) begin
							report_timeout("reset was never released");
						end
						compare_value("flush_o before reset cycle", 32'd0, 32'(flush_o));
						@(negedge clk_i);
						tlb_fill_i.valid = 1'b0;
						compare_value("flush_o in reset cycle", 32'd1, 32'(flush_o));
						@(negedge clk_i);
						compare_value("flush_o after reset cycle", 32'd0, 32'(flush_o));
					end
					1: begin
						@(negedge clk_i);
						tlb_fill_i = '{valid: 1'b1, index: a[TLB_IDX_W-1:0],
						               asid: b[ASID_W-1:0], vpn: c[VPN_W-1:0]};
						@(negedge clk_i);
						tlb_fill_i.valid = 1'b0;
					end
					2: begin
						@(negedge clk_i);
						lookup_asid_i = a[ASID_W-1:0];
						lookup_vpn_i  = b[VPN_W-1:0];
						#1;
						compare_value("tlb_hit_o", 32'(c[0]), 32'(tlb_hit_o));
					end
					3: begin
						@(negedge clk_i);
						commit_i = '{valid: 1'b1, instr: a, asid: b[ASID_W-1:0]};
						@(negedge clk_i);
						commit_i.valid = 1'b0;
						check_pulse(c);
					end
					4: begin
						@(negedge clk_i);
						except_i = '{valid: 1'b1, code: except_code_t'(a[3:0]), at_head: b[0]};
						@(negedge clk_i);
						except_i.valid = 1'b0;
						check_pulse(c);
					end
					5: begin
						@(negedge clk_i);
						dirty_valid_i      = 1'b1;
						dirty_index_i      = a[DC_IDX_W-1:0];
						dirty_data_i       = b;
						exp_dirty[a[DC_IDX_W-1:0]] = 1'b1;
						exp_data[a[DC_IDX_W-1:0]]  = b;
						@(negedge clk_i);
						dirty_valid_i = 1'b0;
					end
					// Environment call write-back, with b refill reads alongside
					6: begin
						wr_addr_q.delete();
						wr_data_q.delete();
						refill_todo = int'(b);
						@(negedge clk_i);
						except_i = '{valid: 1'b1, code: E_ENV_CALL, at_head: 1'b1};
						@(negedge clk_i);
						except_i.valid = 1'b0;
						compare_value("stall_o after env call", 32'd1, 32'(stall_o));
						t = 0;
						while (stall_o && t < 500) begin
							@(negedge clk_i);
							t++;
						end
						if (stall_o) begin
							report_timeout("the write-back never finished");
						end
						compare_value("flush_o after sync", 32'd1, 32'(flush_o));
						@(negedge clk_i);
						compare_value("flush_o one cycle later", 32'd0, 32'(flush_o));
						t = 0;
						while ((refill_todo > 0 || refill_valid_i || rf_exp_q.size() > 0) &&
						       t < 500) begin
							@(negedge clk_i);
							t++;
						end
						if (t >= 500) begin
							report_timeout("refill requests were not all answered");
						end
						compare_value("L2 write count", a, 32'(wr_addr_q.size()));
						k = 0;
						for (int i = 0; i < DC_LINES; i++) begin
							if (exp_dirty[i]) begin
								if (k < wr_addr_q.size()) begin
									compare_value("write addr", 32'(DC_WB_BASE + 16'(i)),
									              32'(wr_addr_q[k]));
									compare_value("write data", exp_data[i], wr_data_q[k]);
								end
								k++;
								exp_dirty[i] = 1'b0;
							end
						end
						compare_value("dirty lines in model", 32'(k), 32'(wr_addr_q.size()));
					end
					default: begin
						$display("Unknown stimulus opcode %h", op);
						other_errs++;
					end
				endcase
			end
			$fclose(fd);
		end
		repeat (2) @(negedge clk_i);
		$display("Errors: %0d value, %0d other", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock (20 ns period) and active-low reset held for the first 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 10,
	parameter int RESET_CYCLES   = 16
) (
	output logic clk_o,
	output logic rst_no
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
	end

	// Release lands in the high phase, away from both edges
	initial begin
		rst_no = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#5;
		rst_no = 1'b1;
	end

endmodule

`default_nettype wire
